/* icache.f */
+incdir+common
common/cacheGeomPkg.sv
common/fetchCtrlPkg.sv
icache/wayStore.sv
icache/plruTree.sv
icache/lookupStage.sv
icache/refillCtrl.sv
icache/instCache.sv
tests/memModel.sv
tests/instCacheTb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - common
    files:
      - common/cacheGeomPkg.sv
      - common/fetchCtrlPkg.sv
      - icache/wayStore.sv
      - icache/plruTree.sv
      - icache/lookupStage.sv
      - icache/refillCtrl.sv
      - icache/instCache.sv
  - target: test
    files:
      - tests/memModel.sv
      - tests/instCacheTb.sv

/* tests/instCacheTb.sv */
module instCacheTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cacheGeomPkg::*;

    localparam int TimeoutCycles = 200;

    logic  clk;
    logic  rst;
    logic  pcValid;
    pcT    pc;
    logic  pcReady;
    logic  inst0Valid;
    pcT    inst0Pc;
    instT  inst0;
    logic  inst1Valid;
    pcT    inst1Pc;
    instT  inst1;
    logic  memReqValid;
    pcT    memReqAddr;
    logic  memReqReady;
    logic  memRespValid;
    logic  memRespReady;
    lineT  memRespLine;
    int    reqCount;
    pcT    lastAddr;
    pcT    expPcs[$];
    int    errCount;
    int    testCount;
    int    failedTests;
    int    testErrBase;
    string currentTest;

    instCache instCache_inst (
        .clk          (clk),
        .rst          (rst),
        .pcValid      (pcValid),
        .pc           (pc),
        .pcReady      (pcReady),
        .inst0Valid   (inst0Valid),
        .inst0Pc      (inst0Pc),
        .inst0        (inst0),
        .inst1Valid   (inst1Valid),
        .inst1Pc      (inst1Pc),
        .inst1        (inst1),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memRespReady (memRespReady),
        .memRespLine  (memRespLine)
    );

    memModel memModelInst (
        .clk          (clk),
        .rst          (rst),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memRespReady (memRespReady),
        .memRespLine  (memRespLine),
        .reqCount     (reqCount),
        .lastAddr     (lastAddr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory pattern seen from the fetch side
    function automatic instT expectedInst(pcT addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    task automatic reportError(string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errCount++;
    endtask

    task automatic abortRun(string msg);
        $display("Timed out: %s", msg);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic startTest(string name);
        currentTest = name;
        testErrBase = errCount;
        testCount++;
    endtask

    task automatic endTest;
        if (errCount == testErrBase) begin
            $display("%s: ok", currentTest);
        end else begin
            $display("%s: %0d errors", currentTest, errCount - testErrBase);
            failedTests++;
        end
    endtask

    //////////////////////////////////////////////////
    // Scoreboard
    task automatic checkResult;
        pcT p;
        pcT pc0;
        pcT pc1;
        if (expPcs.size() == 0) begin
            reportError("result with no fetch outstanding");
            return;
        end
        p   = expPcs.pop_front();
        pc0 = p & ~32'h4;
        pc1 = p | 32'h4;
        if (inst0Pc !== pc0 || inst1Pc !== pc1) begin
            reportError($sformatf("pc %h gave pcs %h %h", p, inst0Pc, inst1Pc));
        end
        if (inst0 !== expectedInst(pc0) || inst1 !== expectedInst(pc1)) begin
            reportError($sformatf("pc %h gave words %h %h", p, inst0, inst1));
        end
        if (inst0Valid !== ~p[2]) begin
            reportError($sformatf("pc %h gave inst0Valid %b", p, inst0Valid));
        end
    endtask

    // Outputs have settled by the falling edge
    always @(negedge clk) begin
        if (inst1Valid === 1'b1) begin
            checkResult();
        end else if (inst0Valid === 1'b1) begin
            reportError("inst0Valid without inst1Valid");
        end
    end

    //////////////////////////////////////////////////
    // Drivers
    task automatic applyReset;
        @(posedge clk);
        rst     <= 1'b1;
        pcValid <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Accepted on the next rising edge once pcReady is seen
    task automatic sendPc(pcT p);
        int cycles;
        @(posedge clk);
        pcValid <= 1'b1;
        pc      <= p;
        cycles = 0;
        @(negedge clk);
        while (pcReady !== 1'b1 && cycles < TimeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (pcReady !== 1'b1) begin
            abortRun("pcReady never came back");
        end else begin
            expPcs.push_back(p);
        end
    endtask

    task automatic endBurst;
        int cycles;
        @(posedge clk);
        pcValid <= 1'b0;
        cycles = 0;
        while (expPcs.size() != 0 && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (expPcs.size() != 0) begin
            abortRun("fetch results missing");
        end
    endtask

    task automatic fetchOne(pcT p);
        sendPc(p);
        endBurst();
    endtask

    task automatic checkRequests(int base, int expected);
        if (reqCount - base != expected) begin
            reportError($sformatf("expected %0d requests, saw %0d", expected, reqCount - base));
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    task automatic testResetState;
        startTest("reset state");
        @(negedge clk);
        if (inst0Valid !== 1'b0 || inst1Valid !== 1'b0) begin
            reportError("instruction valid high after reset");
        end
        if (memReqValid !== 1'b0) begin
            reportError("memReqValid high after reset");
        end
        if (memRespReady !== 1'b0) begin
            reportError("memRespReady high after reset");
        end
        if (pcReady !== 1'b1) begin
            reportError("pcReady low after reset");
        end
        endTest();
    endtask

    task automatic testColdMiss;
        int base;
        startTest("cold miss");
        base = reqCount;
        fetchOne(32'h0000_1238);
        checkRequests(base, 1);
        if (lastAddr !== 32'h0000_1230) begin
            reportError($sformatf("request address %h", lastAddr));
        end
        fetchOne(32'h0000_1238);
        fetchOne(32'h0000_1234);
        checkRequests(base, 1);
        endTest();
    endtask

    task automatic testHitBurst;
        pcT burst [7];
        int base;
        startTest("back-to-back hits");
        fetchOne(32'h0000_2004);
        burst = '{32'h1230, 32'h2008, 32'h1234, 32'h200c, 32'h123c, 32'h2000, 32'h2004};
        base  = reqCount;
        foreach (burst[i]) begin
            sendPc(burst[i]);
        end
        endBurst();
        checkRequests(base, 0);
        endTest();
    endtask

    // Tags A to E all land in set 5
    task automatic testReplacement;
        pcT tagPc [5];
        int base;
        startTest("replacement");
        for (int i = 0; i < 5; i++) begin
            tagPc[i] = pcT'((32'h10 + i) << 10) | (32'd5 << 4);
        end
        base = reqCount;
        for (int i = 0; i < 4; i++) begin
            fetchOne(tagPc[i]);
        end
        fetchOne(tagPc[0] + 32'h4);
        fetchOne(tagPc[4] + 32'h8);
        checkRequests(base, 5);
        // C should be gone while A, B and D stay
        base = reqCount;
        fetchOne(tagPc[0] + 32'hc);
        fetchOne(tagPc[1]);
        fetchOne(tagPc[3] + 32'h4);
        checkRequests(base, 0);
        fetchOne(tagPc[2]);
        checkRequests(base, 1);
        endTest();
    endtask

    task automatic testBackPressure;
        pcT mix [7];
        int base;
        startTest("memory back-pressure");
        mix  = '{32'h8000, 32'h8004, 32'h9014, 32'h123c, 32'h801c, 32'h9018, 32'h8008};
        base = reqCount;
        foreach (mix[i]) begin
            sendPc(mix[i]);
        end
        endBurst();
        checkRequests(base, 3);
        endTest();
    endtask

    task automatic testResetInvalidation;
        int base;
        startTest("reset invalidation");
        applyReset();
        base = reqCount;
        fetchOne(32'h0000_1238);
        checkRequests(base, 1);
        if (lastAddr !== 32'h0000_1230) begin
            reportError($sformatf("request address %h", lastAddr));
        end
        endTest();
    endtask

    initial begin
        rst         = 1'b1;
        pcValid     = 1'b0;
        pc          = '0;
        errCount    = 0;
        testCount   = 0;
        failedTests = 0;
        testErrBase = 0;
        applyReset();
        testResetState();
        testColdMiss();
        testHitBurst();
        testReplacement();
        testBackPressure();
        testResetInvalidation();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tests/memModel.sv */
module memModel (
    input  logic         clk,
    input  logic         rst,
    input  logic         memReqValid,
    input  logic [31:0]  memReqAddr,
    output logic         memReqReady,
    output logic         memRespValid,
    input  logic         memRespReady,
    output logic [127:0] memRespLine,
    output int           reqCount,
    output logic [31:0]  lastAddr
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        mIdle,
        mReqWait,
        mReqAck,
        mRespWait,
        mRespAck
    } memPhaseT;

    memPhaseT phase;
    integer   seed;
    int       delay;

    // Word k of the line at address a
    function automatic logic [31:0] lineWord(logic [31:0] a, int k);
        return (a + 32'(4 * k)) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [127:0] lineAt(logic [31:0] a);
        logic [127:0] line;
        for (int k = 0; k < 4; k++) begin
            line[32 * k +: 32] = lineWord(a, k);
        end
        return line;
    endfunction

    initial begin
        seed         = 32'hacfd_828b;
        reqCount     = 0;
        lastAddr     = '0;
        memReqReady  = 1'b0;
        memRespValid = 1'b0;
        memRespLine  = '0;
        phase        = mIdle;
        delay        = 0;
    end

    // Request and response each wait 0 to 5 cycles
    always @(posedge clk) begin
        if (rst) begin
            phase        <= mIdle;
            memReqReady  <= 1'b0;
            memRespValid <= 1'b0;
        end else begin
            case (phase)
                mIdle: begin
                    if (memReqValid) begin
                        delay <= $unsigned($random(seed)) % 6;
                        phase <= mReqWait;
                    end
                end
                mReqWait: begin
                    if (delay == 0) begin
                        memReqReady <= 1'b1;
                        phase       <= mReqAck;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                mReqAck: begin
                    if (memReqValid && memReqReady) begin
                        memReqReady <= 1'b0;
                        reqCount    <= reqCount + 1;
                        lastAddr    <= memReqAddr;
                        memRespLine <= lineAt(memReqAddr);
                        delay       <= $unsigned($random(seed)) % 6;
                        phase       <= mRespWait;
                    end
                end
                mRespWait: begin
                    if (delay == 0) begin
                        memRespValid <= 1'b1;
                        phase        <= mRespAck;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                default: begin
                    if (memRespValid && memRespReady) begin
                        memRespValid <= 1'b0;
                        phase        <= mIdle;
                    end
                end
            endcase
        end
    end

endmodule

/* icache/instCache.sv */
`include "icache_params.svh"

module instCache (
    input  logic               clk,
    input  logic               rst,
    input  logic               pcValid,
    input  cacheGeomPkg::pcT   pc,
    output logic               pcReady,
    output logic               inst0Valid,
    output cacheGeomPkg::pcT   inst0Pc,
    output cacheGeomPkg::instT inst0,
    output logic               inst1Valid,
    output cacheGeomPkg::pcT   inst1Pc,
    output cacheGeomPkg::instT inst1,
    output logic               memReqValid,
    output cacheGeomPkg::pcT   memReqAddr,
    input  logic               memReqReady,
    input  logic               memRespValid,
    output logic               memRespReady,
    input  cacheGeomPkg::lineT memRespLine
);
    import cacheGeomPkg::*;
    import fetchCtrlPkg::*;

    refillStateT state;
    pcT          s1Pc;
    logic        s1Valid;
    logic        accept;
    setIdxT      rdSet;
    tagT         wayTag  [`ICACHE_WAYS];
    lineT        wayLine [`ICACHE_WAYS];
    wayMaskT     wayValid;
    wayMaskT     wrEn;
    setIdxT      wrSet;
    tagT         wrTag;
    lineT        wrLine;
    logic        miss;
    pcT          missPc;
    logic        hitEn;
    wayIdxT      hitWay;
    wayIdxT      victimWay;
    logic        fillEn;
    wayIdxT      fillWay;
    logic        fillValid;

    //////////////////////////////////////////////////
    // Stage 1
    assign pcReady = (state == sLookup) && !miss;
    assign accept  = pcValid && pcReady;

    // Ways keep reading the held PC while a miss is open
    assign rdSet = pcReady ? setOf(pc) : setOf(s1Pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
        end else if (state == sReplay) begin
            s1Valid <= 1'b0;
        end else if (pcReady) begin
            s1Valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Pc <= pc;
        end
    end

    //////////////////////////////////////////////////
    // Ways, replacement, stage 2 and refill
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : wayGen
        wayStore wayStoreInst (
            .clk     (clk),
            .rst     (rst),
            .rdSet   (rdSet),
            .wrEn    (wrEn[w]),
            .wrSet   (wrSet),
            .wrTag   (wrTag),
            .wrLine  (wrLine),
            .rdTag   (wayTag[w]),
            .rdLine  (wayLine[w]),
            .rdValid (wayValid[w])
        );
    end

    plruTree plruTreeInst (
        .clk       (clk),
        .rst       (rst),
        .set       (setOf(s1Pc)),
        .hitEn     (hitEn),
        .hitWay    (hitWay),
        .fillEn    (fillEn),
        .fillWay   (fillWay),
        .fillSet   (wrSet),
        .victimWay (victimWay)
    );

    lookupStage lookupStageInst (
        .clk        (clk),
        .rst        (rst),
        .stageValid (s1Valid),
        .stagePc    (s1Pc),
        .wayTag     (wayTag),
        .wayLine    (wayLine),
        .wayValid   (wayValid),
        .fillValid  (fillValid),
        .fillLine   (wrLine),
        .miss       (miss),
        .missPc     (missPc),
        .hitEn      (hitEn),
        .hitWay     (hitWay),
        .inst0Valid (inst0Valid),
        .inst0Pc    (inst0Pc),
        .inst0      (inst0),
        .inst1Valid (inst1Valid),
        .inst1Pc    (inst1Pc),
        .inst1      (inst1)
    );

    refillCtrl refillCtrlInst (
        .clk          (clk),
        .rst          (rst),
        .miss         (miss),
        .missPc       (missPc),
        .wayValid     (wayValid),
        .victimWay    (victimWay),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .state        (state),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespReady (memRespReady),
        .wrEn         (wrEn),
        .wrSet        (wrSet),
        .wrTag        (wrTag),
        .wrLine       (wrLine),
        .fillEn       (fillEn),
        .fillWay      (fillWay),
        .fillValid    (fillValid)
    );

endmodule

/* icache/refillCtrl.sv */
`include "icache_params.svh"

module refillCtrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      miss,
    input  cacheGeomPkg::pcT          missPc,
    input  cacheGeomPkg::wayMaskT     wayValid,
    input  cacheGeomPkg::wayIdxT      victimWay,
    input  logic                      memReqReady,
    input  logic                      memRespValid,
    input  cacheGeomPkg::lineT        memRespLine,
    output fetchCtrlPkg::refillStateT state,
    output logic                      memReqValid,
    output cacheGeomPkg::pcT          memReqAddr,
    output logic                      memRespReady,
    output cacheGeomPkg::wayMaskT     wrEn,
    output cacheGeomPkg::setIdxT      wrSet,
    output cacheGeomPkg::tagT         wrTag,
    output cacheGeomPkg::lineT        wrLine,
    output logic                      fillEn,
    output cacheGeomPkg::wayIdxT      fillWay,
    output logic                      fillValid
);
    import cacheGeomPkg::*;
    import fetchCtrlPkg::*;

    refillStateT nextState;
    pcT          heldPc;
    wayIdxT      chosenWay;

    //////////////////////////////////////////////////
    // State machine
    always_comb begin
        nextState = state;
        case (state)
            sLookup: begin
                if (miss) begin
                    nextState = sRequest;
                end
            end
            sRequest: begin
                if (memReqReady) begin
                    nextState = sWait;
                end
            end
            sWait: begin
                if (memRespValid) begin
                    nextState = sReplay;
                end
            end
            default: begin
                nextState = sLookup;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sLookup;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // Victim choice, lowest invalid way first
    always_comb begin
        chosenWay = victimWay;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!wayValid[w]) begin
                chosenWay = wayIdxT'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == sLookup && miss) begin
            heldPc <= missPc;
        end
        if (state == sWait && memRespValid) begin
            wrLine  <= memRespLine;
            fillWay <= chosenWay;
        end
    end

    assign memReqValid  = (state == sRequest);
    assign memReqAddr   = {heldPc[31:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
    assign memRespReady = (state == sWait);

    // Line is written and forwarded in the same cycle
    assign fillEn    = (state == sReplay);
    assign fillValid = fillEn;
    assign wrEn      = wayMaskT'(fillEn) << fillWay;
    assign wrSet     = setOf(heldPc);
    assign wrTag     = tagOf(heldPc);

endmodule

/* icache/lookupStage.sv */
`include "icache_params.svh"

module lookupStage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stageValid,
    input  cacheGeomPkg::pcT      stagePc,
    input  cacheGeomPkg::tagT     wayTag [`ICACHE_WAYS],
    input  cacheGeomPkg::lineT    wayLine [`ICACHE_WAYS],
    input  cacheGeomPkg::wayMaskT wayValid,
    input  logic                  fillValid,
    input  cacheGeomPkg::lineT    fillLine,
    output logic                  miss,
    output cacheGeomPkg::pcT      missPc,
    output logic                  hitEn,
    output cacheGeomPkg::wayIdxT  hitWay,
    output logic                  inst0Valid,
    output cacheGeomPkg::pcT      inst0Pc,
    output cacheGeomPkg::instT    inst0,
    output logic                  inst1Valid,
    output cacheGeomPkg::pcT      inst1Pc,
    output cacheGeomPkg::instT    inst1
);
    import cacheGeomPkg::*;

    wayMaskT hitVec;
    logic    anyHit;
    logic    live;
    logic    outValid;
    logic    missPending;
    lineT    selLine;

    // Tag compare across all ways
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hitVec[w] = wayValid[w] && (wayTag[w] == tagOf(stagePc));
        end
    end

    always_comb begin
        hitWay = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (hitVec[w]) begin
                hitWay = wayIdxT'(w);
            end
        end
    end

    assign anyHit = |hitVec;

    // Entry that missed waits here for the refill line
    always_ff @(posedge clk) begin
        if (rst) begin
            missPending <= 1'b0;
        end else if (fillValid) begin
            missPending <= 1'b0;
        end else if (miss) begin
            missPending <= 1'b1;
        end
    end

    assign live     = stageValid && !missPending;
    assign hitEn    = live && anyHit;
    assign miss     = live && !anyHit;
    assign missPc   = stagePc;
    assign outValid = hitEn || fillValid;
    assign selLine  = fillValid ? fillLine : wayLine[hitWay];

    // Aligned pair, bit 3 picks the half of the line
    assign inst0Pc    = {stagePc[31:3], 1'b0, stagePc[1:0]};
    assign inst1Pc    = {stagePc[31:3], 1'b1, stagePc[1:0]};
    assign inst0      = wordOf(selLine, {stagePc[3], 1'b0});
    assign inst1      = wordOf(selLine, {stagePc[3], 1'b1});
    assign inst0Valid = outValid && !stagePc[2];
    assign inst1Valid = outValid;

endmodule

/* icache/plruTree.sv */
`include "icache_params.svh"

module plruTree (
    input  logic                 clk,
    input  logic                 rst,
    input  cacheGeomPkg::setIdxT set,
    input  logic                 hitEn,
    input  cacheGeomPkg::wayIdxT hitWay,
    input  logic                 fillEn,
    input  cacheGeomPkg::wayIdxT fillWay,
    input  cacheGeomPkg::setIdxT fillSet,
    output cacheGeomPkg::wayIdxT victimWay
);
    import cacheGeomPkg::*;

    logic [2:0] bits [`ICACHE_SETS];
    logic [2:0] fillBits;
    wayIdxT     victimNext;

    // Point the tree away from the way just used
    function automatic logic [2:0] touch(logic [2:0] cur, wayIdxT way);
        logic [2:0] nxt;
        nxt = cur;
        case (way)
            2'd0: nxt = {1'b1, cur[1], 1'b1};
            2'd1: nxt = {1'b1, cur[1], 1'b0};
            2'd2: nxt = {1'b0, 1'b1, cur[0]};
            default: nxt = {1'b0, 1'b0, cur[0]};
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                bits[s] <= 3'b000;
            end
        end else begin
            if (hitEn) begin
                bits[set] <= touch(bits[set], hitWay);
            end
            if (fillEn) begin
                bits[fillSet] <= touch(bits[fillSet], fillWay);
            end
        end
    end

    // b2 picks the half, b0 or b1 picks the way in it
    assign fillBits   = bits[fillSet];
    assign victimNext = fillBits[2] ? {1'b1, fillBits[1]} : {1'b0, fillBits[0]};

    always_ff @(posedge clk) begin
        victimWay <= victimNext;
    end

endmodule

/* icache/wayStore.sv */
`include "icache_params.svh"

module wayStore (
    input  logic                 clk,
    input  logic                 rst,
    input  cacheGeomPkg::setIdxT rdSet,
    input  logic                 wrEn,
    input  cacheGeomPkg::setIdxT wrSet,
    input  cacheGeomPkg::tagT    wrTag,
    input  cacheGeomPkg::lineT   wrLine,
    output cacheGeomPkg::tagT    rdTag,
    output cacheGeomPkg::lineT   rdLine,
    output logic                 rdValid
);
    import cacheGeomPkg::*;

    tagT                     tags  [`ICACHE_SETS];
    lineT                    lines [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid;

    // Tag and line arrays, old data on a same-set read
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tags[wrSet]  <= wrTag;
            lines[wrSet] <= wrLine;
        end
        rdTag  <= tags[rdSet];
        rdLine <= lines[rdSet];
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= '0;
            rdValid <= 1'b0;
        end else begin
            if (wrEn) begin
                valid[wrSet] <= 1'b1;
            end
            rdValid <= valid[rdSet];
        end
    end

endmodule

/* common/fetchCtrlPkg.sv */
package fetchCtrlPkg;

    // Refill controller states
    typedef enum logic [1:0] {
        sLookup,
        sRequest,
        sWait,
        sReplay
    } refillStateT;

endpackage

/* common/cacheGeomPkg.sv */
`include "icache_params.svh"

package cacheGeomPkg;

    typedef logic [31:0]                     pcT;
    typedef logic [`ICACHE_TAG_W-1:0]        tagT;
    typedef logic [`ICACHE_IDX_W-1:0]        setIdxT;
    typedef logic [`ICACHE_LINE_W-1:0]       lineT;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] wayIdxT;
    typedef logic [`ICACHE_WAYS-1:0]         wayMaskT;
    typedef logic [`ICACHE_WORD_W-1:0]       instT;

    // Tag is everything above index and offset
    function automatic tagT tagOf(pcT addr);
        return addr[`ICACHE_OFS_W + `ICACHE_IDX_W +: `ICACHE_TAG_W];
    endfunction

    function automatic setIdxT setOf(pcT addr);
        return addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
    endfunction

    // Word k of a line
    function automatic instT wordOf(lineT line, logic [1:0] k);
        return line[k * `ICACHE_WORD_W +: `ICACHE_WORD_W];
    endfunction

endpackage

/* common/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Cache geometry
`define ICACHE_WAYS   4
`define ICACHE_SETS   64
`define ICACHE_TAG_W  22
`define ICACHE_IDX_W  6
`define ICACHE_OFS_W  4

// Line and word widths
`define ICACHE_LINE_W 128
`define ICACHE_WORD_W 32

`endif
